/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing -j 0
TOP = tb_sha256
FILELIST = files.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
hw/sha256_pkg.sv
hw/wb_map_pkg.sv
hw/hash_ctrl_if.sv
hw/wb_sha_regs.sv
hw/msg_schedule.sv
hw/sha_round.sv
hw/sha256_wb_top.sv
sim/sha_checker.sv
sim/tb_sha256.sv

/* hw/hash_ctrl_if.sv */
interface hash_ctrl_if;
	import sha256_pkg::*;

	logic start;
	msg_block_t block;
	logic busy;
	logic done;
	sha_state_u digest;

	modport regs (
		output start, block,
		input busy, done, digest
	);

	modport sched (
		input start, block
	);

	modport engine (
		input start,
		output busy, done, digest
	);

endinterface

/* hw/msg_schedule.sv */
module msg_schedule (
	input logic clk,
	input logic rst_n,
	hash_ctrl_if.sched ctrl,
	input logic step,
	output sha256_pkg::word_t w
);
	import sha256_pkg::*;

	msg_block_t win;
	word_t w_new;

	function automatic word_t ssig0(word_t x);
		return rotr(x, SSIG0_R1) ^ rotr(x, SSIG0_R2) ^ (x >> SSIG0_SH);
	endfunction

	function automatic word_t ssig1(word_t x);
		return rotr(x, SSIG1_R1) ^ rotr(x, SSIG1_R2) ^ (x >> SSIG1_SH);
	endfunction

	// W[t] from W[t-2], W[t-7], W[t-15] and W[t-16]
	assign w_new = ssig1(win[BLOCK_WORDS-2]) + win[BLOCK_WORDS-7] +
		ssig0(win[BLOCK_WORDS-15]) + win[BLOCK_WORDS-16];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			win <= '0;
		end else if (ctrl.start) begin
			win <= ctrl.block;
		end else if (step) begin
			for (int i = 0; i < BLOCK_WORDS - 1; i++) begin
				win[i] <= win[i+1];
			end
			win[BLOCK_WORDS-1] <= w_new;
		end
	end

	// Oldest entry is the current round's W
	assign w = win[0];

endmodule

/* hw/sha256_pkg.sv */
package sha256_pkg;

	localparam int NUM_ROUNDS = 64;
	localparam int BLOCK_WORDS = 16;
	localparam int STATE_WORDS = 8;
	localparam int ROUND_W = $clog2(NUM_ROUNDS);

	typedef logic [31:0] word_t;
	typedef logic [ROUND_W-1:0] round_t;

	// Word 0 is the first message word
	typedef word_t [0:BLOCK_WORDS-1] msg_block_t;

	typedef struct packed {
		word_t a;
		word_t b;
		word_t c;
		word_t d;
		word_t e;
		word_t f;
		word_t g;
		word_t h;
	} sha_vars_t;

	// Field a lines up with words[0] and H0
	typedef union packed {
		sha_vars_t vars;
		word_t [0:STATE_WORDS-1] words;
	} sha_state_u;

	localparam word_t ROUND_K [NUM_ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam word_t INIT_H [STATE_WORDS] = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	// Big sigma rotations
	localparam int BSIG0_R1 = 2;
	localparam int BSIG0_R2 = 13;
	localparam int BSIG0_R3 = 22;
	localparam int BSIG1_R1 = 6;
	localparam int BSIG1_R2 = 11;
	localparam int BSIG1_R3 = 25;

	// Small sigma rotations and shifts
	localparam int SSIG0_R1 = 7;
	localparam int SSIG0_R2 = 18;
	localparam int SSIG0_SH = 3;
	localparam int SSIG1_R1 = 17;
	localparam int SSIG1_R2 = 19;
	localparam int SSIG1_SH = 10;

	function automatic word_t rotr(word_t x, int unsigned n);
		return (x >> n) | (x << ($bits(word_t) - n));
	endfunction

endpackage

/* hw/sha256_wb_top.sv */
module sha256_wb_top (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [wb_map_pkg::ADR_W-1:0] wb_adr,
	input sha256_pkg::word_t wb_dat_w,
	output sha256_pkg::word_t wb_dat_r,
	output logic wb_ack
);
	import sha256_pkg::*;

	word_t w;
	logic step;

	hash_ctrl_if ctrl_if ();

	wb_sha_regs wb_sha_regs_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.ctrl     (ctrl_if.regs)
	);

	// Window feeds one W per round
	msg_schedule msg_schedule_i (
		.clk   (clk),
		.rst_n (rst_n),
		.ctrl  (ctrl_if.sched),
		.step  (step),
		.w     (w)
	);

	sha_round sha_round_i (
		.clk   (clk),
		.rst_n (rst_n),
		.ctrl  (ctrl_if.engine),
		.w     (w),
		.step  (step)
	);

endmodule

/* hw/sha_round.sv */
module sha_round (
	input logic clk,
	input logic rst_n,
	hash_ctrl_if.engine ctrl,
	input sha256_pkg::word_t w,
	output logic step
);
	import sha256_pkg::*;

	sha_state_u st;
	sha_state_u nxt;
	sha_state_u digest_q;
	round_t round;
	logic busy_q;
	logic done_q;
	logic finishing;
	word_t t1;
	word_t t2;

	function automatic word_t bsig0(word_t x);
		return rotr(x, BSIG0_R1) ^ rotr(x, BSIG0_R2) ^ rotr(x, BSIG0_R3);
	endfunction

	function automatic word_t bsig1(word_t x);
		return rotr(x, BSIG1_R1) ^ rotr(x, BSIG1_R2) ^ rotr(x, BSIG1_R3);
	endfunction

	function automatic word_t ch(word_t x, word_t y, word_t z);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic word_t maj(word_t x, word_t y, word_t z);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

	always_comb begin
		t1 = st.vars.h + bsig1(st.vars.e) + ch(st.vars.e, st.vars.f, st.vars.g) +
			ROUND_K[round] + w;
		t2 = bsig0(st.vars.a) + maj(st.vars.a, st.vars.b, st.vars.c);
		nxt.vars.a = t1 + t2;
		nxt.vars.b = st.vars.a;
		nxt.vars.c = st.vars.b;
		nxt.vars.d = st.vars.c;
		nxt.vars.e = st.vars.d + t1;
		nxt.vars.f = st.vars.e;
		nxt.vars.g = st.vars.f;
		nxt.vars.h = st.vars.g;
	end

	// Working variables
	always_ff @(posedge clk) begin
		if (ctrl.start) begin
			for (int i = 0; i < STATE_WORDS; i++) begin
				st.words[i] <= INIT_H[i];
			end
		end else if (step) begin
			st <= nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy_q <= 1'b0;
			done_q <= 1'b0;
			finishing <= 1'b0;
			round <= '0;
			digest_q <= '0;
		end else if (ctrl.start) begin
			busy_q <= 1'b1;
			done_q <= 1'b0;
			finishing <= 1'b0;
			round <= '0;
		end else if (finishing) begin
			// Final addition of the initial hash
			for (int i = 0; i < STATE_WORDS; i++) begin
				digest_q.words[i] <= st.words[i] + INIT_H[i];
			end
			busy_q <= 1'b0;
			done_q <= 1'b1;
			finishing <= 1'b0;
		end else if (busy_q) begin
			round <= round + 1'b1;
			if (round == round_t'(NUM_ROUNDS - 1)) begin
				finishing <= 1'b1;
			end
		end
	end

	assign step = busy_q && !finishing;

	assign ctrl.busy = busy_q;
	assign ctrl.done = done_q;
	assign ctrl.digest = digest_q;

endmodule

/* hw/wb_map_pkg.sv */
package wb_map_pkg;

	localparam int ADR_W = 5;

	// Low address bits that pick a word inside a register bank
	localparam int MSG_IDX_W = 4;
	localparam int DIGEST_IDX_W = 3;

	localparam logic [ADR_W-1:0] ADR_MSG_BASE = 5'd0;
	localparam logic [ADR_W-1:0] ADR_CTRL = 5'd16;
	localparam logic [ADR_W-1:0] ADR_STATUS = 5'd17;
	localparam logic [ADR_W-1:0] ADR_DIGEST_BASE = 5'd24;

	localparam int CTRL_START_BIT = 0;

	localparam int STATUS_BUSY_BIT = 0;
	localparam int STATUS_DONE_BIT = 1;

endpackage

/* hw/wb_sha_regs.sv */
module wb_sha_regs (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [wb_map_pkg::ADR_W-1:0] wb_adr,
	input sha256_pkg::word_t wb_dat_w,
	output sha256_pkg::word_t wb_dat_r,
	output logic wb_ack,
	hash_ctrl_if.regs ctrl
);
	import sha256_pkg::*;
	import wb_map_pkg::*;

	logic req;
	logic new_req;
	logic wr_en;
	logic msg_hit;
	logic dig_hit;
	logic [MSG_IDX_W-1:0] msg_idx;
	logic [DIGEST_IDX_W-1:0] dig_idx;
	logic start_q;
	msg_block_t msg_q;
	word_t rd_data;

	assign req = wb_cyc && wb_stb;
	// Ack low for a clock before the next request is taken
	assign new_req = req && !wb_ack;
	assign wr_en = new_req && wb_we;

	assign msg_hit = wb_adr[ADR_W-1:MSG_IDX_W] == ADR_MSG_BASE[ADR_W-1:MSG_IDX_W];
	assign dig_hit = wb_adr[ADR_W-1:DIGEST_IDX_W] == ADR_DIGEST_BASE[ADR_W-1:DIGEST_IDX_W];
	assign msg_idx = wb_adr[MSG_IDX_W-1:0];
	assign dig_idx = wb_adr[DIGEST_IDX_W-1:0];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			start_q <= 1'b0;
			msg_q <= '0;
		end else begin
			wb_ack <= new_req;
			// Start while busy is acked but dropped
			start_q <= wr_en && (wb_adr == ADR_CTRL) && wb_dat_w[CTRL_START_BIT] &&
				!ctrl.busy;
			if (wr_en && msg_hit) begin
				msg_q[msg_idx] <= wb_dat_w;
			end
		end
	end

	always_comb begin
		rd_data = '0;
		if (msg_hit) begin
			rd_data = msg_q[msg_idx];
		end else if (wb_adr == ADR_STATUS) begin
			rd_data[STATUS_BUSY_BIT] = ctrl.busy;
			rd_data[STATUS_DONE_BIT] = ctrl.done;
		end else if (dig_hit) begin
			rd_data = ctrl.digest.words[dig_idx];
		end
	end

	// Read data captured with the ack
	always_ff @(posedge clk) begin
		if (new_req) begin
			wb_dat_r <= rd_data;
		end
	end

	assign ctrl.start = start_q;
	assign ctrl.block = msg_q;

endmodule

/* sim/sha_checker.sv */
module sha_checker (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [wb_map_pkg::ADR_W-1:0] wb_adr,
	input sha256_pkg::word_t wb_dat_w,
	input sha256_pkg::word_t wb_dat_r,
	input logic wb_ack
);
	import sha256_pkg::*;
	import wb_map_pkg::*;

	localparam logic [255:0] ABC_DIGEST =
		256'hba7816bf8f01cfea414140de5dae2223b00361a396177a9cb410ff61f20015ad;

	int err_count = 0;
	int check_count = 0;

	// Bus and engine model, updated on the same edges as the DUT
	msg_block_t msg_m;
	logic [0:STATE_WORDS-1][31:0] dig_m;
	logic [0:STATE_WORDS-1][31:0] res_m;
	logic ack_m;
	logic start_m;
	logic busy_m;
	logic done_m;
	logic [6:0] cnt_m;
	logic rd_pend;
	logic [ADR_W-1:0] rd_adr;
	word_t rd_exp;
	logic new_req;

	function automatic word_t ror(word_t x, int n);
		logic [63:0] d;
		d = {x, x} >> n;
		return d[31:0];
	endfunction

	function automatic logic [0:7][31:0] compress(input msg_block_t blk);
		word_t w [64];
		word_t a, b, c, d, e, f, g, h, t1, t2;
		for (int i = 0; i < 16; i++) begin
			w[i] = blk[i];
		end
		for (int i = 16; i < 64; i++) begin
			w[i] = (ror(w[i-2], 17) ^ ror(w[i-2], 19) ^ (w[i-2] >> 10)) + w[i-7] +
				(ror(w[i-15], 7) ^ ror(w[i-15], 18) ^ (w[i-15] >> 3)) + w[i-16];
		end
		{a, b, c, d, e, f, g, h} = {INIT_H[0], INIT_H[1], INIT_H[2], INIT_H[3],
			INIT_H[4], INIT_H[5], INIT_H[6], INIT_H[7]};
		for (int i = 0; i < 64; i++) begin
			t1 = h + (ror(e, 6) ^ ror(e, 11) ^ ror(e, 25)) + ((e & f) ^ (~e & g)) +
				ROUND_K[i] + w[i];
			t2 = (ror(a, 2) ^ ror(a, 13) ^ ror(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
			h = g;
			g = f;
			f = e;
			e = d + t1;
			d = c;
			c = b;
			b = a;
			a = t1 + t2;
		end
		return {a + INIT_H[0], b + INIT_H[1], c + INIT_H[2], d + INIT_H[3],
			e + INIT_H[4], f + INIT_H[5], g + INIT_H[6], h + INIT_H[7]};
	endfunction

	function automatic word_t expected_read(logic [ADR_W-1:0] adr);
		word_t r;
		r = '0;
		if (adr < ADR_CTRL) begin
			r = msg_m[adr[3:0]];
		end else if (adr == ADR_STATUS) begin
			r[STATUS_BUSY_BIT] = busy_m;
			r[STATUS_DONE_BIT] = done_m;
		end else if (adr >= ADR_DIGEST_BASE) begin
			r = dig_m[adr[2:0]];
		end
		return r;
	endfunction

	// Standard test vector for the one-block message "abc"
	initial begin
		msg_block_t kat;
		kat = '0;
		kat[0] = 32'h61626380;
		kat[15] = 32'h00000018;
		if (compress(kat) !== ABC_DIGEST) begin
			$display("Reference model does not reproduce the digest of abc");
			err_count++;
		end
	end

	assign new_req = wb_cyc && wb_stb && !ack_m;

	always @(posedge clk) begin
		if (!rst_n) begin
			ack_m <= 1'b0;
			start_m <= 1'b0;
			busy_m <= 1'b0;
			done_m <= 1'b0;
			cnt_m <= '0;
			rd_pend <= 1'b0;
			msg_m <= '0;
			dig_m <= '0;
		end else begin
			if (wb_ack !== ack_m) begin
				$display("ERR t=%0t wb_ack exp=%b got=%b", $time, ack_m, wb_ack);
				err_count++;
			end
			if (ack_m && rd_pend) begin
				check_count++;
				if (wb_dat_r !== rd_exp) begin
					$display("ERR t=%0t wb_dat_r adr=%0d exp=%h got=%h", $time, rd_adr,
						rd_exp, wb_dat_r);
					err_count++;
				end
			end
			ack_m <= new_req;
			start_m <= 1'b0;
			if (new_req) begin
				rd_pend <= !wb_we;
				rd_adr <= wb_adr;
				rd_exp <= expected_read(wb_adr);
				if (wb_we && wb_adr < ADR_CTRL) begin
					msg_m[wb_adr[3:0]] <= wb_dat_w;
				end
				if (wb_we && wb_adr == ADR_CTRL && wb_dat_w[CTRL_START_BIT] && !busy_m) begin
					start_m <= 1'b1;
				end
			end
			if (start_m) begin
				busy_m <= 1'b1;
				done_m <= 1'b0;
				cnt_m <= '0;
				res_m <= compress(msg_m);
			end else if (busy_m) begin
				// 64 rounds and then the final addition edge
				if (cnt_m == 7'd64) begin
					busy_m <= 1'b0;
					done_m <= 1'b1;
					dig_m <= res_m;
				end else begin
					cnt_m <= cnt_m + 7'd1;
				end
			end
		end
	end

endmodule

/* sim/tb_sha256.sv */
module tb_sha256;
	import sha256_pkg::*;
	import wb_map_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_RANDOM = 20;
	localparam int NUM_TESTS = NUM_RANDOM + 6;
	localparam int WATCHDOG_TIME = NUM_TESTS * (90 + 65) * 4 * CLK_PERIOD;
	localparam int POLL_LIMIT = 200;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [ADR_W-1:0] wb_adr;
	word_t wb_dat_w;
	word_t wb_dat_r;
	logic wb_ack;

	int tests_run = 0;
	int tests_failed = 0;
	int tb_errors = 0;
	int errs_before = 0;
	msg_block_t blk;
	word_t rd;

	sha256_wb_top sha256_wb_top_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	sha_checker sha_checker_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired before all tests finished");
		$display("Test failures found");
		$finish;
	end

	task automatic bus_write(input logic [ADR_W-1:0] adr, input word_t data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b1;
		wb_adr <= adr;
		wb_dat_w <= data;
		do @(posedge clk); while (!wb_ack);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we <= 1'b0;
	endtask

	task automatic bus_read(input logic [ADR_W-1:0] adr, output word_t data);
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we <= 1'b0;
		wb_adr <= adr;
		do @(posedge clk); while (!wb_ack);
		data = wb_dat_r;
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	task automatic random_block(output msg_block_t b);
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			b[i] = $urandom;
		end
	endtask

	task automatic write_block(input msg_block_t b);
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			bus_write(ADR_MSG_BASE + ADR_W'(i), b[i]);
		end
	endtask

	task automatic start_hash();
		bus_write(ADR_CTRL, word_t'(1) << CTRL_START_BIT);
	endtask

	task automatic wait_done();
		word_t st;
		int polls;
		polls = 0;
		do begin
			bus_read(ADR_STATUS, st);
			polls++;
		end while (!st[STATUS_DONE_BIT] && polls < POLL_LIMIT);
		if (!st[STATUS_DONE_BIT]) begin
			$display("Done bit never rose after start at t=%0t", $time);
			tb_errors++;
		end
	endtask

	// Digest values are compared by the checker
	task automatic read_digest();
		word_t d;
		for (int i = 0; i < STATE_WORDS; i++) begin
			bus_read(ADR_DIGEST_BASE + ADR_W'(i), d);
		end
	endtask

	task automatic hash_block(input msg_block_t b);
		write_block(b);
		start_hash();
		wait_done();
		read_digest();
	endtask

	task automatic finish_test(input string name);
		int errs;
		@(posedge clk);
		errs = sha_checker_i.err_count + tb_errors;
		tests_run++;
		if (errs != errs_before) begin
			tests_failed++;
			$display("FAIL %s (%0d errors)", name, errs - errs_before);
		end else begin
			$display("PASS %s", name);
		end
		errs_before = errs;
	endtask

	initial begin
		void'($urandom(32'h72ce_78ef));
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		bus_read(ADR_STATUS, rd);
		read_digest();
		finish_test("reset values");

		random_block(blk);
		write_block(blk);
		for (int i = 0; i < BLOCK_WORDS; i++) begin
			bus_read(ADR_MSG_BASE + ADR_W'(i), rd);
		end
		bus_write(ADR_STATUS, $urandom);
		bus_write(ADR_DIGEST_BASE, $urandom);
		for (int a = 17; a < 32; a++) begin
			bus_read(ADR_W'(a), rd);
		end
		finish_test("register readback");

		blk = '0;
		hash_block(blk);
		finish_test("zero block");
		for (int n = 0; n < NUM_RANDOM; n++) begin
			random_block(blk);
			hash_block(blk);
			finish_test($sformatf("random block %0d", n));
		end

		// Old digest stays visible during the run
		random_block(blk);
		write_block(blk);
		start_hash();
		bus_read(ADR_STATUS, rd);
		read_digest();
		wait_done();
		read_digest();
		finish_test("reads while busy");

		random_block(blk);
		write_block(blk);
		start_hash();
		random_block(blk);
		write_block(blk);
		wait_done();
		read_digest();
		start_hash();
		wait_done();
		read_digest();
		finish_test("overwrite during run");

		random_block(blk);
		write_block(blk);
		start_hash();
		// Changed word 0 shows in the digest only if the second start runs
		bus_write(ADR_MSG_BASE, ~blk[0]);
		start_hash();
		wait_done();
		read_digest();
		// A second run would show busy again here
		repeat (70) @(posedge clk);
		bus_read(ADR_STATUS, rd);
		finish_test("start while busy");

		$display("Tests run %0d, failed %0d, errors %0d, read checks %0d", tests_run,
			tests_failed, errs_before, sha_checker_i.check_count);
		if (tests_failed == 0 && errs_before == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
